/* Makefile */
# Verilator build and run of the copper subsystem testbench

VERILATOR ?= verilator
TOP       ?= copper_tb
FILELIST  ?= copper_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* copper_top.f */
src/copper_pkg.sv
src/raster_timer.sv
src/copper_ram.sv
src/copper_ctrl.sv
src/vdp_reg_file.sv
src/copper_top.sv
verif/copper_tb.sv

/* src/copper_ctrl.sv */
/*
 * Copper control unit
 * Fetches and decodes display-list instructions, tracks the raster
 * targets, stalls on raster waits and issues video register writes
 * that are held until the register file accepts them.
 */

`timescale 1ns/1ps

module copper_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   copper_enable,
    input  copper_pkg::raster_x_t  raster_x,
    input  copper_pkg::raster_y_t  raster_y,
    output copper_pkg::prog_addr_t ram_read_address,
    input  copper_pkg::prog_word_t ram_read_data,
    output logic                   copper_write_en,
    output copper_pkg::vreg_addr_t copper_write_address,
    output copper_pkg::vreg_data_t copper_write_data,
    input  logic                   write_ready
);

    copper_pkg::copper_state_t state;
    copper_pkg::prog_addr_t    pc;
    copper_pkg::raster_x_t     target_x;
    copper_pkg::raster_y_t     target_y;

    copper_pkg::copper_op_t    op;
    logic                      op_target_wait;
    logic                      op_target_select;
    logic [10:0]               op_target_value;
    logic                      target_hit;

    // instruction fields, valid while the fetched word is present
    assign op               = copper_pkg::copper_op_t'(ram_read_data[15:13]);
    assign op_target_wait   = ram_read_data[12];
    assign op_target_select = ram_read_data[11];
    assign op_target_value  = ram_read_data[10:0];

    assign target_hit = (raster_x == target_x) && (raster_y == target_y);

    assign ram_read_address = pc;

    // write request stays up for the whole hold state, dropped at once on disable
    assign copper_write_en = copper_enable && (state == copper_pkg::ST_WRITE_HOLD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= copper_pkg::ST_OP_FETCH;
            pc       <= '0;
            target_x <= '0;
            target_y <= '0;
        end else if (!copper_enable) begin
            state    <= copper_pkg::ST_OP_FETCH;
            pc       <= '0;
            target_x <= '0;
            target_y <= '0;
        end else begin
            case (state)
                copper_pkg::ST_OP_FETCH: begin
                    // pc is on the RAM address this cycle
                    state <= copper_pkg::ST_OP_DECODE;
                end

                copper_pkg::ST_OP_DECODE: begin
                    case (op)
                        copper_pkg::OP_SET_TARGET, copper_pkg::OP_WAIT_TARGET: begin
                            if (op_target_select) begin
                                target_y <= op_target_value[9:0];
                            end else begin
                                target_x <= op_target_value;
                            end
                            if (op_target_wait) begin
                                state <= copper_pkg::ST_RASTER_WAIT;
                            end else begin
                                pc    <= pc + 1'b1;
                                state <= copper_pkg::ST_OP_FETCH;
                            end
                        end
                        copper_pkg::OP_WRITE_REG: begin
                            // pc moves onto the data word
                            pc    <= pc + 1'b1;
                            state <= copper_pkg::ST_DATA_FETCH;
                        end
                        copper_pkg::OP_JUMP: begin
                            pc    <= op_target_value;
                            state <= copper_pkg::ST_OP_FETCH;
                        end
                        default: begin
                            // unnamed codes are skipped
                            pc    <= pc + 1'b1;
                            state <= copper_pkg::ST_OP_FETCH;
                        end
                    endcase
                end

                copper_pkg::ST_DATA_FETCH: begin
                    state <= copper_pkg::ST_DATA_DECODE;
                end

                copper_pkg::ST_DATA_DECODE: begin
                    // data word is latched into the write payload below
                    state <= copper_pkg::ST_WRITE_HOLD;
                end

                copper_pkg::ST_WRITE_HOLD: begin
                    // commit edge, step past the data word
                    if (write_ready) begin
                        pc    <= pc + 1'b1;
                        state <= copper_pkg::ST_OP_FETCH;
                    end
                end

                copper_pkg::ST_RASTER_WAIT: begin
                    if (target_hit) begin
                        pc    <= pc + 1'b1;
                        state <= copper_pkg::ST_OP_FETCH;
                    end
                end

                default: begin
                    state <= copper_pkg::ST_OP_FETCH;
                end
            endcase
        end
    end

    // write payload, stable through the hold state
    always_ff @(posedge clk) begin
        if (state == copper_pkg::ST_OP_DECODE) begin
            copper_write_address <= ram_read_data[5:0];
        end
        if (state == copper_pkg::ST_DATA_DECODE) begin
            copper_write_data <= ram_read_data;
        end
    end

endmodule

/* src/copper_pkg.sv */
/*
 * Copper subsystem definitions
 * Width types for beam position, program memory and video registers,
 * plus the instruction opcode and control state encodings.
 */

package copper_pkg;

    typedef logic [10:0] raster_x_t;
    typedef logic [9:0]  raster_y_t;
    typedef logic [10:0] prog_addr_t;
    typedef logic [15:0] prog_word_t;
    typedef logic [5:0]  vreg_addr_t;
    typedef logic [15:0] vreg_data_t;

    // instruction word layout, opcode in bits 15..13
    //
    // SET_TARGET / WAIT_TARGET
    //   bit 12     wait until the beam reaches the target
    //   bit 11     1 selects the y target, 0 the x target
    //   bits 10..0 target value, y uses bits 9..0 only
    // WRITE_REG
    //   bits 5..0  register index, the following word is the data
    // JUMP
    //   bits 10..0 new program address
    //
    // codes 4 to 7 are skipped
    typedef enum logic [2:0] {
        OP_SET_TARGET  = 3'd0,
        OP_WAIT_TARGET = 3'd1,
        OP_WRITE_REG   = 3'd2,
        OP_JUMP        = 3'd3
    } copper_op_t;

    typedef enum logic [2:0] {
        ST_OP_FETCH,
        ST_OP_DECODE,
        ST_DATA_FETCH,
        ST_DATA_DECODE,
        ST_WRITE_HOLD,
        ST_RASTER_WAIT
    } copper_state_t;

endpackage

/* src/copper_ram.sv */
/*
 * Copper program RAM
 * 2048 x 16 words, host write port and a registered read port
 * for the copper. Shaped to infer a simple dual-port block RAM.
 */

`timescale 1ns/1ps

module copper_ram (
    input  logic                   clk,
    input  logic                   prog_write_en,
    input  copper_pkg::prog_addr_t prog_write_address,
    input  copper_pkg::prog_word_t prog_write_data,
    input  copper_pkg::prog_addr_t ram_read_address,
    output copper_pkg::prog_word_t ram_read_data
);

    localparam int DEPTH = 2 ** $bits(copper_pkg::prog_addr_t);

    copper_pkg::prog_word_t mem [DEPTH];

    // host loads the program while the copper is stopped
    always_ff @(posedge clk) begin
        if (prog_write_en) begin
            mem[prog_write_address] <= prog_write_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        ram_read_data <= mem[ram_read_address];
    end

endmodule

/* src/copper_top.sv */
/*
 * Copper subsystem top level
 * Raster timer, program RAM, copper control and the video register
 * file, with the raster totals passed down from here.
 */

`timescale 1ns/1ps

module copper_top #(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   copper_enable,
    input  logic                   prog_write_en,
    input  copper_pkg::prog_addr_t prog_write_address,
    input  copper_pkg::prog_word_t prog_write_data,
    input  logic                   host_write_en,
    input  copper_pkg::vreg_addr_t host_write_address,
    input  copper_pkg::vreg_data_t host_write_data,
    input  copper_pkg::vreg_addr_t host_read_address,
    output copper_pkg::vreg_data_t host_read_data,
    output copper_pkg::raster_x_t  raster_x,
    output copper_pkg::raster_y_t  raster_y,
    output logic                   frame_start,
    output logic                   vreg_write_en,
    output copper_pkg::vreg_addr_t vreg_write_address,
    output copper_pkg::vreg_data_t vreg_write_data,
    output logic                   vreg_write_src
);

    copper_pkg::prog_addr_t ram_read_address;
    copper_pkg::prog_word_t ram_read_data;
    logic                   copper_write_en;
    copper_pkg::vreg_addr_t copper_write_address;
    copper_pkg::vreg_data_t copper_write_data;
    logic                   write_ready;

    raster_timer #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) u_raster_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .raster_x    (raster_x),
        .raster_y    (raster_y),
        .frame_start (frame_start)
    );

    copper_ram u_copper_ram (
        .clk                (clk),
        .prog_write_en      (prog_write_en),
        .prog_write_address (prog_write_address),
        .prog_write_data    (prog_write_data),
        .ram_read_address   (ram_read_address),
        .ram_read_data      (ram_read_data)
    );

    copper_ctrl u_copper_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .copper_enable        (copper_enable),
        .raster_x             (raster_x),
        .raster_y             (raster_y),
        .ram_read_address     (ram_read_address),
        .ram_read_data        (ram_read_data),
        .copper_write_en      (copper_write_en),
        .copper_write_address (copper_write_address),
        .copper_write_data    (copper_write_data),
        .write_ready          (write_ready)
    );

    vdp_reg_file u_vdp_reg_file (
        .clk                  (clk),
        .rst_n                (rst_n),
        .host_write_en        (host_write_en),
        .host_write_address   (host_write_address),
        .host_write_data      (host_write_data),
        .host_read_address    (host_read_address),
        .host_read_data       (host_read_data),
        .copper_write_en      (copper_write_en),
        .copper_write_address (copper_write_address),
        .copper_write_data    (copper_write_data),
        .write_ready          (write_ready),
        .vreg_write_en        (vreg_write_en),
        .vreg_write_address   (vreg_write_address),
        .vreg_write_data      (vreg_write_data),
        .vreg_write_src       (vreg_write_src)
    );

endmodule

/* src/raster_timer.sv */
/*
 * Raster timer
 * Free-running horizontal and vertical beam counters. frame_start
 * pulses for one cycle while the beam sits at position (0,0).
 */

`timescale 1ns/1ps

module raster_timer #(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                  clk,
    input  logic                  rst_n,
    output copper_pkg::raster_x_t raster_x,
    output copper_pkg::raster_y_t raster_y,
    output logic                  frame_start
);

    localparam copper_pkg::raster_x_t X_LAST = copper_pkg::raster_x_t'(H_TOTAL - 1);
    localparam copper_pkg::raster_y_t Y_LAST = copper_pkg::raster_y_t'(V_TOTAL - 1);

    logic line_end;
    logic frame_end;

    assign line_end  = (raster_x == X_LAST);
    assign frame_end = line_end && (raster_y == Y_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raster_x    <= '0;
            raster_y    <= '0;
            frame_start <= 1'b0;
        end else begin
            // registered so the pulse coincides with x = 0, y = 0
            frame_start <= frame_end;

            if (line_end) begin
                raster_x <= '0;
                if (frame_end) begin
                    raster_y <= '0;
                end else begin
                    raster_y <= raster_y + 1'b1;
                end
            end else begin
                raster_x <= raster_x + 1'b1;
            end
        end
    end

endmodule

/* src/vdp_reg_file.sv */
/*
 * Video register file
 * 64 x 16 registers written by the host and the copper, host first.
 * Each committed write is echoed as a one-cycle change pulse.
 */

`timescale 1ns/1ps

module vdp_reg_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   host_write_en,
    input  copper_pkg::vreg_addr_t host_write_address,
    input  copper_pkg::vreg_data_t host_write_data,
    input  copper_pkg::vreg_addr_t host_read_address,
    output copper_pkg::vreg_data_t host_read_data,
    input  logic                   copper_write_en,
    input  copper_pkg::vreg_addr_t copper_write_address,
    input  copper_pkg::vreg_data_t copper_write_data,
    output logic                   write_ready,
    output logic                   vreg_write_en,
    output copper_pkg::vreg_addr_t vreg_write_address,
    output copper_pkg::vreg_data_t vreg_write_data,
    output logic                   vreg_write_src
);

    localparam int NUM_REGS = 2 ** $bits(copper_pkg::vreg_addr_t);

    copper_pkg::vreg_data_t regs [NUM_REGS];

    logic                   commit_en;
    logic                   commit_copper;
    copper_pkg::vreg_addr_t commit_address;
    copper_pkg::vreg_data_t commit_data;

    // host wins any cycle it writes
    assign write_ready    = !host_write_en;
    assign commit_copper  = copper_write_en && !host_write_en;
    assign commit_en      = host_write_en || copper_write_en;
    assign commit_address = host_write_en ? host_write_address : copper_write_address;
    assign commit_data    = host_write_en ? host_write_data : copper_write_data;

    assign host_read_data = regs[host_read_address];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (commit_en) begin
            regs[commit_address] <= commit_data;
        end
    end

    // change pulse for the rest of the VDP
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vreg_write_en  <= 1'b0;
            vreg_write_src <= 1'b0;
        end else begin
            vreg_write_en  <= commit_en;
            vreg_write_src <= commit_copper;
        end
    end

    always_ff @(posedge clk) begin
        vreg_write_address <= commit_address;
        vreg_write_data    <= commit_data;
    end

endmodule

/* verif/copper_tb.sv */
/*
 * Copper subsystem testbench
 * Loads copper programs through the host port, runs frames on a short
 * raster and checks writes, raster waits, back-pressure and restart.
 */

`timescale 1ns/1ps

module copper_tb;

    localparam int H_TOTAL      = 48;
    localparam int V_TOTAL      = 12;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

    logic                   clk;
    logic                   rst_n;
    logic                   copper_enable;
    logic                   prog_write_en;
    copper_pkg::prog_addr_t prog_write_address;
    copper_pkg::prog_word_t prog_write_data;
    logic                   host_write_en;
    copper_pkg::vreg_addr_t host_write_address;
    copper_pkg::vreg_data_t host_write_data;
    copper_pkg::vreg_addr_t host_read_address;
    copper_pkg::vreg_data_t host_read_data;
    copper_pkg::raster_x_t  raster_x;
    copper_pkg::raster_y_t  raster_y;
    logic                   frame_start;
    logic                   vreg_write_en;
    copper_pkg::vreg_addr_t vreg_write_address;
    copper_pkg::vreg_data_t vreg_write_data;
    logic                   vreg_write_src;

    copper_pkg::prog_word_t prog_q[$];
    logic [31:0]            rng_state = 32'd91;
    int                     value_errors = 0;
    int                     protocol_errors = 0;
    int                     frame_commits = 0;
    logic                   loop_armed;
    // beam position one cycle back, i.e. during the commit cycle
    copper_pkg::raster_x_t  beam_x_prev;
    copper_pkg::raster_y_t  beam_y_prev;

    // control state of the copper
    copper_pkg::copper_state_t ctrl_state;
    assign ctrl_state = UUT.u_copper_ctrl.state;

    copper_top #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) UUT (
        .clk(clk), .rst_n(rst_n), .copper_enable(copper_enable),
        .prog_write_en(prog_write_en), .prog_write_address(prog_write_address),
        .prog_write_data(prog_write_data), .host_write_en(host_write_en),
        .host_write_address(host_write_address), .host_write_data(host_write_data),
        .host_read_address(host_read_address), .host_read_data(host_read_data),
        .raster_x(raster_x), .raster_y(raster_y), .frame_start(frame_start),
        .vreg_write_en(vreg_write_en), .vreg_write_address(vreg_write_address),
        .vreg_write_data(vreg_write_data), .vreg_write_src(vreg_write_src)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        beam_x_prev <= raster_x;
        beam_y_prev <= raster_y;
        if (frame_start) begin
            frame_commits <= (vreg_write_en && vreg_write_src) ? 1 : 0;
        end else if (vreg_write_en && vreg_write_src) begin
            frame_commits <= frame_commits + 1;
        end
    end

    no_commit_under_host: assert property (@(posedge clk) disable iff (!rst_n)
        (vreg_write_en && vreg_write_src) |-> !$past(host_write_en))
    else begin
        protocol_errors++;
        $display("copper write committed while the host was writing");
    end

    no_commit_disabled: assert property (@(posedge clk) disable iff (!rst_n)
        (vreg_write_en && vreg_write_src) |-> $past(copper_enable))
    else begin
        protocol_errors++;
        $display("copper write committed while the copper was disabled");
    end

    one_commit_per_frame: assert property (@(posedge clk) disable iff (!rst_n)
        (frame_start && loop_armed) |-> (frame_commits == 1))
    else begin
        protocol_errors++;
        $display("a frame of the jump loop did not hold exactly one copper write");
    end

    commit_after_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(host_write_en) |=> (vreg_write_en && vreg_write_src))
    else begin
        protocol_errors++;
        $display("stalled copper write did not commit right after the host released");
    end

    stall_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (ctrl_state == copper_pkg::ST_WRITE_HOLD && host_write_en && copper_enable)
            |=> (ctrl_state == copper_pkg::ST_WRITE_HOLD))
    else begin
        protocol_errors++;
        $display("copper left the write hold while the host was writing");
    end

    // pulse exactly when the beam wraps from the last position to (0,0)
    frame_start_at_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        frame_start == (raster_x == '0 && raster_y == '0
                        && $past(raster_x) == H_TOTAL - 1
                        && $past(raster_y) == V_TOTAL - 1))
    else begin
        protocol_errors++;
        $display("frame start pulse did not line up with the beam wrapping to the origin");
    end

    function automatic logic [31:0] xorshift_next();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // instruction encoders, opcode in the top three bits
    function automatic copper_pkg::prog_word_t target_word(logic wait_flag, logic select_y,
                                                           logic [10:0] value);
        copper_pkg::copper_op_t op;
        op = wait_flag ? copper_pkg::OP_WAIT_TARGET : copper_pkg::OP_SET_TARGET;
        return {op, wait_flag, select_y, value};
    endfunction

    function automatic copper_pkg::prog_word_t reg_write_word(copper_pkg::vreg_addr_t index);
        return {copper_pkg::OP_WRITE_REG, 7'd0, index};
    endfunction

    function automatic copper_pkg::prog_word_t jump_word(copper_pkg::prog_addr_t address);
        return {copper_pkg::OP_JUMP, 2'd0, address};
    endfunction

    task automatic step();
        @(posedge clk);
        #0.5;
    endtask

    task automatic abort_run(string what);
        $display("timeout while waiting for %s", what);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        $display("Verification failed");
        $finish;
    endtask

    task automatic check_value(string test_name, logic [31:0] expected, logic [31:0] actual);
        assert (actual == expected) else begin
            value_errors++;
            $display("[FAIL] %s: expected %0h, actual %0h", test_name, expected, actual);
        end
    endtask

    task automatic check_commit(string test_name, copper_pkg::vreg_addr_t index,
                                copper_pkg::vreg_data_t value);
        check_value({test_name, " address"}, 32'(index), 32'(vreg_write_address));
        check_value({test_name, " data"}, 32'(value), 32'(vreg_write_data));
    endtask

    task automatic check_register(string test_name, copper_pkg::vreg_addr_t index,
                                  copper_pkg::vreg_data_t value);
        host_read_address = index;
        #0.5;
        check_value(test_name, 32'(value), 32'(host_read_data));
    endtask

    task automatic load_program();
        copper_enable = 1'b0;
        step();
        foreach (prog_q[i]) begin
            prog_write_en      = 1'b1;
            prog_write_address = copper_pkg::prog_addr_t'(i);
            prog_write_data    = prog_q[i];
            step();
        end
        prog_write_en = 1'b0;
    endtask

    task automatic load_and_start();
        load_program();
        copper_enable = 1'b1;
    endtask

    // y target, wait on x, one register write, then loop or halt
    task automatic build_wait_program(copper_pkg::raster_y_t ty, copper_pkg::raster_x_t tx,
                                      copper_pkg::vreg_addr_t index,
                                      copper_pkg::vreg_data_t value, logic repeat_frames);
        prog_q = {target_word(1'b0, 1'b1, 11'(ty)), target_word(1'b1, 1'b0, tx),
                  reg_write_word(index), value,
                  jump_word(repeat_frames ? 11'd0 : 11'd4)};
    endtask

    task automatic wait_copper_commit(string what, int limit, output int cycles);
        cycles = 0;
        while (!(vreg_write_en && vreg_write_src)) begin
            if (cycles >= limit) begin
                abort_run(what);
            end
            step();
            cycles++;
        end
    endtask

    task automatic wait_frame_start(int limit);
        int n;
        n = 0;
        while (!frame_start) begin
            if (n >= limit) begin
                abort_run("frame start");
            end
            step();
            n++;
        end
    endtask

    task automatic wait_beam(copper_pkg::raster_x_t tx, copper_pkg::raster_y_t ty, int limit);
        int n;
        n = 0;
        while (!(raster_x == tx && raster_y == ty)) begin
            if (n >= limit) begin
                abort_run("beam position");
            end
            step();
            n++;
        end
    endtask

    task automatic count_copper_commits(int cycles, output int count);
        count = 0;
        repeat (cycles) begin
            step();
            if (vreg_write_en && vreg_write_src) begin
                count++;
            end
        end
    endtask

    initial begin
        copper_pkg::vreg_addr_t idx;
        copper_pkg::vreg_addr_t host_idx;
        copper_pkg::vreg_data_t data;
        copper_pkg::vreg_data_t host_data;
        copper_pkg::raster_x_t  tx;
        copper_pkg::raster_y_t  ty;
        int                     cycles;
        int                     count;

        rst_n              = 1'b0;
        copper_enable      = 1'b0;
        prog_write_en      = 1'b0;
        prog_write_address = '0;
        prog_write_data    = '0;
        host_write_en      = 1'b0;
        host_write_address = '0;
        host_write_data    = '0;
        host_read_address  = '0;
        loop_armed         = 1'b0;
        repeat (5) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        step();

        // single write, four cycles to the hold plus the commit edge
        idx  = copper_pkg::vreg_addr_t'(xorshift_next());
        data = copper_pkg::vreg_data_t'(xorshift_next());
        prog_q = {reg_write_word(idx), data, jump_word(11'd2)};
        load_and_start();
        wait_copper_commit("register write", 20, cycles);
        check_value("register write latency", 32'd5, 32'(cycles));
        check_commit("register write", idx, data);
        count_copper_commits(40, count);
        check_value("register write extra pulses", 32'd0, 32'(count));
        check_register("register write readback", idx, data);

        // raster wait, commit lands five columns past the x target
        for (int t = 0; t < 4; t++) begin
            ty   = copper_pkg::raster_y_t'(xorshift_next() % V_TOTAL);
            tx   = copper_pkg::raster_x_t'(xorshift_next() % (H_TOTAL - 8));
            idx  = copper_pkg::vreg_addr_t'(xorshift_next());
            data = copper_pkg::vreg_data_t'(xorshift_next());
            build_wait_program(ty, tx, idx, data, 1'b0);
            load_and_start();
            wait_copper_commit("raster wait write", 2 * FRAME_CYCLES + 40, cycles);
            check_value("raster wait line", 32'(ty), 32'(beam_y_prev));
            check_value("raster wait column", 32'(tx) + 32'd5, 32'(beam_x_prev));
            check_commit("raster wait write", idx, data);
        end

        // jump loop over four whole frames
        ty   = copper_pkg::raster_y_t'(2 + xorshift_next() % 8);
        tx   = copper_pkg::raster_x_t'(xorshift_next() % (H_TOTAL - 8));
        idx  = copper_pkg::vreg_addr_t'(xorshift_next());
        data = copper_pkg::vreg_data_t'(xorshift_next());
        build_wait_program(ty, tx, idx, data, 1'b1);
        load_and_start();
        wait_frame_start(2 * FRAME_CYCLES);
        step();
        loop_armed = 1'b1;
        repeat (4) begin
            step();
            wait_frame_start(2 * FRAME_CYCLES);
        end
        step();
        loop_armed    = 1'b0;
        copper_enable = 1'b0;

        // host writes across the commit window
        ty        = copper_pkg::raster_y_t'(2 + xorshift_next() % 8);
        tx        = copper_pkg::raster_x_t'(xorshift_next() % 30);
        idx       = copper_pkg::vreg_addr_t'(xorshift_next());
        host_idx  = idx ^ 6'd1;
        data      = copper_pkg::vreg_data_t'(xorshift_next());
        host_data = copper_pkg::vreg_data_t'(xorshift_next());
        build_wait_program(ty, tx, idx, data, 1'b0);
        wait_frame_start(2 * FRAME_CYCLES);
        load_and_start();
        wait_beam(tx, ty, 2 * FRAME_CYCLES);
        host_write_en      = 1'b1;
        host_write_address = host_idx;
        host_write_data    = host_data;
        repeat (12) step();
        host_write_en = 1'b0;
        wait_copper_commit("write after back-pressure", 4, cycles);
        check_value("back-pressure release delay", 32'd1, 32'(cycles));
        check_commit("back-pressure write", idx, data);
        step();
        check_register("back-pressure copper register", idx, data);
        check_register("back-pressure host register", host_idx, host_data);

        // disable during the write hold, then restart from address 0
        idx  = copper_pkg::vreg_addr_t'(xorshift_next());
        data = copper_pkg::vreg_data_t'(xorshift_next());
        prog_q = {reg_write_word(idx), data, jump_word(11'd2)};
        load_program();
        copper_enable = 1'b1;
        repeat (4) step();
        // write request is up here
        copper_enable = 1'b0;
        count_copper_commits(30, count);
        check_value("disabled copper writes", 32'd0, 32'(count));
        copper_enable = 1'b1;
        wait_copper_commit("first run write", 20, cycles);
        check_value("first run write latency", 32'd5, 32'(cycles));
        check_commit("first run write", idx, data);
        repeat (10) step();
        copper_enable = 1'b0;
        count_copper_commits(20, count);
        check_value("disabled copper writes after run", 32'd0, 32'(count));
        copper_enable = 1'b1;
        wait_copper_commit("restart write", 20, cycles);
        check_value("restart write latency", 32'd5, 32'(cycles));
        check_commit("restart write", idx, data);
        count_copper_commits(40, count);
        check_value("restart extra pulses", 32'd0, 32'(count));

        // plain target and opcode 5 take two cycles each
        idx  = copper_pkg::vreg_addr_t'(xorshift_next());
        data = copper_pkg::vreg_data_t'(xorshift_next());
        prog_q = {target_word(1'b0, 1'b0, 11'(xorshift_next())),
                  copper_pkg::prog_word_t'({3'd5, 13'(xorshift_next())}),
                  reg_write_word(idx), data, jump_word(11'd4)};
        load_and_start();
        wait_copper_commit("write after skipped words", 20, cycles);
        check_value("skip latency", 32'd9, 32'(cycles));
        check_commit("write after skipped words", idx, data);

        step();
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
